// File: sources.f
src/recorder_pkg.sv
src/keypad_debounce.sv
src/keypad_decoder.sv
src/track_directory.sv
src/record_counter.sv
src/recorder_menu.sv
src/recorder_top.sv
verification/recorder_properties.sv
verification/recorder_tb.sv

// File: Bender.yml
package:
  name: recorder

sources:
  - src/recorder_pkg.sv
  - src/keypad_debounce.sv
  - src/keypad_decoder.sv
  - src/track_directory.sv
  - src/record_counter.sv
  - src/recorder_menu.sv
  - src/recorder_top.sv
  - target: test
    files:
      - verification/recorder_properties.sv
      - verification/recorder_tb.sv

// File: verification/recorder_tb.sv
`timescale 1ns/1ps

module recorder_tb;
	import recorder_pkg::*;

	////////////////////////////////////////
	// Run limits
	////////////////////////////////////////

	localparam int RESET_CYCLES = 16;
	// Random extra hold, and idle time before the stop key
	localparam int HOLD_MAX = 8;
	localparam int STOP_WAIT_MAX = 16;
	// Press to strobe plus release to idle, worst case
	localparam int PRESS_CYCLES = 2 * (DEBOUNCE_DIV * (DEBOUNCE_COUNT + 1) + 4) + HOLD_MAX;
	localparam int ROW_CYCLES = 2 * PRESS_CYCLES + STOP_WAIT_MAX + TRACK_SPAN;
	localparam int MARGIN_CYCLES = 200;

	// One table row
	typedef struct packed {
		key_t key;
		volume_t volume;
		track_mask_t valid;
		logic full;
		logic is_rec;
		logic to_limit;
	} step_t;

	logic pb_clk;
	logic pb_reset;
	logic [KEYPAD_LINES-1:0] kypd_row;
	logic [KEYPAD_LINES-1:0] kypd_col;
	menu_state_t menu_state;
	volume_t volume;
	track_mask_t track_valid;
	logic mem_full;
	logic recording;
	addr_t rec_address;

	step_t steps[$];
	int errors;
	int unsigned cycle_cnt;
	int unsigned timeout_cycles;
	// Region of the recording in progress
	addr_t cur_base;
	addr_t cur_limit;
	// Cycles seen with recording high, one address each
	int unsigned rec_cycles;

	recorder_top dut_i (
		.pb_clk(pb_clk),
		.pb_reset(pb_reset),
		.kypd_row(kypd_row),
		.kypd_col(kypd_col),
		.menu_state(menu_state),
		.volume(volume),
		.track_valid(track_valid),
		.mem_full(mem_full),
		.recording(recording),
		.rec_address(rec_address)
	);

	// Checker sees the internal press strobe too
	bind recorder_top recorder_properties props_i (
		.pb_clk(pb_clk),
		.pb_reset(pb_reset),
		.key_press(key_press),
		.mem_full(mem_full),
		.track_valid(track_valid),
		.volume(volume),
		.recording(recording),
		.rec_address(rec_address)
	);

	initial begin
		pb_clk = 1'b0;
		forever #4 pb_clk = ~pb_clk;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
		end
	endtask

	task automatic add_row(input key_t k, input volume_t v, input track_mask_t m,
		input logic f, input logic r, input logic l);
		step_t row;
		row.key = k;
		row.volume = v;
		row.valid = m;
		row.full = f;
		row.is_rec = r;
		row.to_limit = l;
		steps.push_back(row);
	endtask

	// Matrix lines of a key, rows in the upper nibble
	function automatic logic [7:0] key_lines(input key_t k);
		case (k)
			KEY_1: return 8'b0001_0001;
			KEY_2: return 8'b0001_0010;
			KEY_3: return 8'b0001_0100;
			KEY_A: return 8'b0001_1000;
			KEY_4: return 8'b0010_0001;
			KEY_5: return 8'b0010_0010;
			KEY_6: return 8'b0010_0100;
			KEY_B: return 8'b0010_1000;
			KEY_0: return 8'b1000_0001;
			default: return 8'h00;
		endcase
	endfunction

	// Track that a new recording should take
	function automatic int lowest_free(input track_mask_t mask);
		for (int i = 0; i < NUM_TRACKS; i++) begin
			if (!mask[i]) begin
				return i;
			end
		end
		return 0;
	endfunction

	// Hold until the DUT strobes, then release until the code goes idle
	task automatic press_key(input key_t k);
		logic [7:0] lines;
		int unsigned hold;
		lines = key_lines(k);
		hold = $urandom % HOLD_MAX;
		@(posedge pb_clk);
		kypd_row <= lines[7:4];
		kypd_col <= lines[3:0];
		do begin
			@(posedge pb_clk);
		end while (!dut_i.key_press);
		repeat (hold) @(posedge pb_clk);
		kypd_row <= '0;
		kypd_col <= '0;
		do begin
			@(posedge pb_clk);
		end while (dut_i.key != KEY_NONE);
	endtask

	// Main, delete and volume menus wait for keys
	task automatic wait_idle();
		do begin
			@(posedge pb_clk);
		end while (recording || !(menu_state == ST_MENU || menu_state == ST_DELETE_MENU
			|| menu_state == ST_VOLUME));
	endtask

	task automatic build_table();
		// Tracks fill from 0 upward, track 2 runs to its limit
		add_row(KEY_2, 3'd0, 5'h01, 1'b0, 1'b1, 1'b0);
		add_row(KEY_2, 3'd0, 5'h03, 1'b0, 1'b1, 1'b0);
		add_row(KEY_2, 3'd0, 5'h07, 1'b0, 1'b1, 1'b1);
		add_row(KEY_2, 3'd0, 5'h0F, 1'b0, 1'b1, 1'b0);
		add_row(KEY_2, 3'd0, 5'h1F, 1'b1, 1'b1, 1'b0);
		// Sixth attempt finds no room
		add_row(KEY_2, 3'd0, 5'h1F, 1'b1, 1'b0, 1'b0);
		// Delete track 3 through the delete menu, then refill it
		add_row(KEY_3, 3'd0, 5'h1F, 1'b1, 1'b0, 1'b0);
		add_row(KEY_4, 3'd0, 5'h17, 1'b0, 1'b0, 1'b0);
		add_row(KEY_0, 3'd0, 5'h17, 1'b0, 1'b0, 1'b0);
		add_row(KEY_2, 3'd0, 5'h1F, 1'b1, 1'b1, 1'b0);
		add_row(KEY_4, 3'd0, 5'h00, 1'b0, 1'b0, 1'b0);
		// Volume menu, up past max and down past zero
		add_row(KEY_5, 3'd0, 5'h00, 1'b0, 1'b0, 1'b0);
		for (int i = 1; i <= 8; i++) begin
			add_row(KEY_A, volume_t'((i < VOLUME_MAX) ? i : VOLUME_MAX), 5'h00, 1'b0, 1'b0, 1'b0);
		end
		for (int i = 1; i <= 8; i++) begin
			add_row(KEY_B, volume_t'((i < VOLUME_MAX) ? VOLUME_MAX - i : 0), 5'h00, 1'b0,
				1'b0, 1'b0);
		end
		add_row(KEY_0, 3'd0, 5'h00, 1'b0, 1'b0, 1'b0);
	endtask

	////////////////////////////////////////
	// Monitor and timeout
	////////////////////////////////////////

	// Write address stays inside the allocated region
	always @(posedge pb_clk) begin
		if (recording) begin
			rec_cycles++;
		end
		if (recording && (rec_address < cur_base || rec_address > cur_limit)) begin
			check_value("rec_address", rec_address,
				(rec_address < cur_base) ? cur_base : cur_limit);
		end
	end

	initial begin
		cycle_cnt = 0;
		@(posedge pb_clk);
		timeout_cycles = RESET_CYCLES + steps.size() * ROW_CYCLES + MARGIN_CYCLES;
		while (cycle_cnt < timeout_cycles) begin
			@(posedge pb_clk);
			cycle_cnt++;
		end
		$display("ERROR: run did not finish within %0d cycles", timeout_cycles);
		$display("Closing: %0d check errors, timeout reached", errors);
		$display("Testbench failed");
		$finish;
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial begin
		step_t row;
		int track;
		int unsigned stop_wait;
		track_mask_t prev_valid;
		errors = 0;
		void'($urandom(80));
		pb_reset = 1'b1;
		kypd_row = '0;
		kypd_col = '0;
		cur_base = '0;
		cur_limit = '0;
		rec_cycles = 0;
		track = 0;
		build_table();
		repeat (RESET_CYCLES) @(posedge pb_clk);
		pb_reset <= 1'b0;
		// One cycle in ST_INIT first
		repeat (3) @(posedge pb_clk);
		check_value("menu_state", menu_state, ST_MENU);
		check_value("track_valid", track_valid, '0);
		check_value("mem_full", mem_full, 1'b0);
		check_value("volume", volume, '0);
		prev_valid = '0;
		foreach (steps[i]) begin
			row = steps[i];
			if (row.is_rec) begin
				track = lowest_free(prev_valid);
				cur_base = addr_t'(track * TRACK_SPAN);
				cur_limit = addr_t'(track * TRACK_SPAN + TRACK_SPAN - 1);
				rec_cycles = 0;
			end
			press_key(row.key);
			if (row.is_rec) begin
				check_value("recording", recording, 1'b1);
				if (!row.to_limit) begin
					stop_wait = $urandom % STOP_WAIT_MAX;
					repeat (stop_wait) @(posedge pb_clk);
					press_key(KEY_0);
				end
			end
			wait_idle();
			// Last written address
			if (row.is_rec && row.to_limit) begin
				check_value("rec_address", rec_address, cur_limit);
			end else if (row.is_rec) begin
				check_value("rec_address below limit", rec_address < cur_limit, 1'b1);
			end
			// Stored end is one address per recording cycle past the base
			if (row.is_rec) begin
				check_value("end_addr", dut_i.directory_i.end_addr[track],
					addr_t'(cur_base + rec_cycles - 1));
			end
			check_value("volume", volume, row.volume);
			check_value("track_valid", track_valid, row.valid);
			check_value("mem_full", mem_full, row.full);
			prev_valid = row.valid;
		end
		$display("Closing: %0d check errors over %0d rows", errors, steps.size());
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: verification/recorder_properties.sv
`timescale 1ns/1ps

module recorder_properties (
	input logic pb_clk,
	input logic pb_reset,
	input logic key_press,
	input logic mem_full,
	input recorder_pkg::track_mask_t track_valid,
	input recorder_pkg::volume_t volume,
	input logic recording,
	input recorder_pkg::addr_t rec_address
);
	import recorder_pkg::*;

	////////////////////////////////////////
	// Keypad and directory
	////////////////////////////////////////

	// Press strobe is a single cycle
	a_press_pulse: assert property (@(posedge pb_clk) disable iff (pb_reset)
		key_press |=> !key_press)
		else $error("key_press high for two cycles");

	// Full only with every track taken
	a_full_mask: assert property (@(posedge pb_clk) disable iff (pb_reset)
		mem_full |-> (&track_valid))
		else $error("mem_full set with a free track");

	////////////////////////////////////////
	// Volume and recording
	////////////////////////////////////////

	// No wrap from the top
	a_volume_top: assert property (@(posedge pb_clk) disable iff (pb_reset)
		(volume == VOLUME_MAX) |=> (volume != '0))
		else $error("volume wrapped from max to zero");

	// No wrap from the bottom
	a_volume_bottom: assert property (@(posedge pb_clk) disable iff (pb_reset)
		(volume == '0) |=> (volume != VOLUME_MAX))
		else $error("volume wrapped from zero to max");

	// Write address steps by one while recording goes on
	a_addr_step: assert property (@(posedge pb_clk) disable iff (pb_reset)
		recording |=> (!recording || (rec_address == addr_t'($past(rec_address) + 1'b1))))
		else $error("rec_address did not advance by one");

endmodule

// File: src/recorder_top.sv
`timescale 1ns/1ps

module recorder_top (
	input logic pb_clk,
	input logic pb_reset,
	input logic [recorder_pkg::KEYPAD_LINES-1:0] kypd_row,
	input logic [recorder_pkg::KEYPAD_LINES-1:0] kypd_col,
	output recorder_pkg::menu_state_t menu_state,
	output recorder_pkg::volume_t volume,
	output recorder_pkg::track_mask_t track_valid,
	output logic mem_full,
	output logic recording,
	output recorder_pkg::addr_t rec_address
);
	import recorder_pkg::*;

	// Keypad path
	logic [KEYPAD_LINES-1:0] row_clean;
	logic [KEYPAD_LINES-1:0] col_clean;
	key_t key;
	logic key_press;

	// Directory and counter control
	logic alloc;
	logic alloc_ok;
	track_idx_t alloc_track;
	logic rec_start;
	logic rec_stop;
	logic rec_done;
	track_idx_t rec_track;
	addr_t end_address;
	logic del_one;
	logic del_all;
	track_idx_t del_track;

	////////////////////////////////////////
	// Keypad
	////////////////////////////////////////

	keypad_debounce debounce_i (
		.pb_clk(pb_clk),
		.pb_reset(pb_reset),
		.kypd_row(kypd_row),
		.kypd_col(kypd_col),
		.row_clean(row_clean),
		.col_clean(col_clean)
	);

	keypad_decoder decoder_i (
		.pb_clk(pb_clk),
		.pb_reset(pb_reset),
		.row_clean(row_clean),
		.col_clean(col_clean),
		.key(key),
		.key_press(key_press)
	);

	////////////////////////////////////////
	// Menu, directory and counter
	////////////////////////////////////////

	// Directory full flag is the memory-full indication
	recorder_menu menu_i (
		.pb_clk(pb_clk),
		.pb_reset(pb_reset),
		.key(key),
		.key_press(key_press),
		.alloc_ok(alloc_ok),
		.full(mem_full),
		.alloc_track(alloc_track),
		.rec_done(rec_done),
		.alloc(alloc),
		.rec_start(rec_start),
		.rec_stop(rec_stop),
		.del_one(del_one),
		.del_all(del_all),
		.rec_track(rec_track),
		.del_track(del_track),
		.volume(volume),
		.menu_state(menu_state)
	);

	track_directory directory_i (
		.pb_clk(pb_clk),
		.pb_reset(pb_reset),
		.alloc(alloc),
		.del_one(del_one),
		.del_all(del_all),
		.rec_done(rec_done),
		.del_track(del_track),
		.end_address(end_address),
		.alloc_ok(alloc_ok),
		.full(mem_full),
		.alloc_track(alloc_track),
		.track_valid(track_valid)
	);

	record_counter counter_i (
		.pb_clk(pb_clk),
		.pb_reset(pb_reset),
		.rec_start(rec_start),
		.rec_stop(rec_stop),
		.rec_track(rec_track),
		.recording(recording),
		.rec_done(rec_done),
		.rec_address(rec_address),
		.end_address(end_address)
	);

endmodule

// File: src/recorder_menu.sv
`timescale 1ns/1ps

module recorder_menu (
	input logic pb_clk,
	input logic pb_reset,
	input recorder_pkg::key_t key,
	input logic key_press,
	input logic alloc_ok,
	input logic full,
	input recorder_pkg::track_idx_t alloc_track,
	input logic rec_done,
	output logic alloc,
	output logic rec_start,
	output logic rec_stop,
	output logic del_one,
	output logic del_all,
	output recorder_pkg::track_idx_t rec_track,
	output recorder_pkg::track_idx_t del_track,
	output recorder_pkg::volume_t volume,
	output recorder_pkg::menu_state_t menu_state
);
	import recorder_pkg::*;

	track_idx_t sel_track;
	logic sel_ok;

	// Keys 1 to 5 name tracks 0 to 4
	always_comb begin
		sel_ok = 1'b1;
		case (key)
			KEY_1: sel_track = 3'd0;
			KEY_2: sel_track = 3'd1;
			KEY_3: sel_track = 3'd2;
			KEY_4: sel_track = 3'd3;
			KEY_5: sel_track = 3'd4;
			default: begin
				sel_track = 3'd0;
				sel_ok = 1'b0;
			end
		endcase
	end

	////////////////////////////////////////
	// Menu FSM
	////////////////////////////////////////

	always_ff @(posedge pb_clk or posedge pb_reset) begin
		if (pb_reset) begin
			menu_state <= ST_INIT;
			volume <= '0;
			alloc <= 1'b0;
			rec_start <= 1'b0;
			rec_track <= '0;
			del_track <= '0;
		end else begin
			alloc <= 1'b0;
			rec_start <= 1'b0;
			case (menu_state)
				ST_INIT: menu_state <= ST_MENU;
				// Main menu, one action per press
				ST_MENU: begin
					if (key_press) begin
						case (key)
							KEY_2: begin
								menu_state <= ST_RECORD_INIT;
								alloc <= 1'b1;
							end
							KEY_3: menu_state <= ST_DELETE_MENU;
							KEY_4: menu_state <= ST_DELETE_ALL;
							KEY_5: menu_state <= ST_VOLUME;
							default: menu_state <= ST_MENU;
						endcase
					end
				end
				// Answer comes the cycle after the request
				ST_RECORD_INIT: begin
					if (!alloc) begin
						if (alloc_ok) begin
							rec_track <= alloc_track;
							rec_start <= 1'b1;
							menu_state <= ST_RECORD;
						end else if (full) begin
							menu_state <= ST_MEM_FULL;
						end
					end
				end
				ST_RECORD: begin
					if (rec_done) begin
						menu_state <= ST_END_RECORD;
					end
				end
				ST_DELETE_MENU: begin
					if (key_press) begin
						if (sel_ok) begin
							del_track <= sel_track;
							menu_state <= ST_DELETE;
						end else if (key == KEY_0) begin
							menu_state <= ST_MENU;
						end
					end
				end
				ST_VOLUME: begin
					if (key_press) begin
						case (key)
							KEY_A: menu_state <= ST_VOLUME_UP;
							KEY_B: menu_state <= ST_VOLUME_DOWN;
							KEY_0: menu_state <= ST_MENU;
							default: menu_state <= ST_VOLUME;
						endcase
					end
				end
				// Volume saturates at both ends
				ST_VOLUME_UP: begin
					if (volume != VOLUME_MAX) begin
						volume <= volume + 1'b1;
					end
					menu_state <= ST_VOLUME;
				end
				ST_VOLUME_DOWN: begin
					if (volume != '0) begin
						volume <= volume - 1'b1;
					end
					menu_state <= ST_VOLUME;
				end
				// Single-cycle actions fall back to the main menu
				ST_END_RECORD, ST_DELETE, ST_DELETE_ALL, ST_MEM_FULL: menu_state <= ST_MENU;
				default: menu_state <= ST_INIT;
			endcase
		end
	end

	// Delete strobes last as long as their one-cycle states
	assign del_one = (menu_state == ST_DELETE);
	assign del_all = (menu_state == ST_DELETE_ALL);

	// Stop key only matters during a recording
	assign rec_stop = key_press && (key == KEY_0) && (menu_state == ST_RECORD);

endmodule

// File: src/record_counter.sv
`timescale 1ns/1ps

module record_counter (
	input logic pb_clk,
	input logic pb_reset,
	input logic rec_start,
	input logic rec_stop,
	input recorder_pkg::track_idx_t rec_track,
	output logic recording,
	output logic rec_done,
	output recorder_pkg::addr_t rec_address,
	output recorder_pkg::addr_t end_address
);
	import recorder_pkg::*;

	addr_t limit_addr;

	// Region limit latched with the start
	always_ff @(posedge pb_clk or posedge pb_reset) begin
		if (pb_reset) begin
			limit_addr <= '0;
		end else if (rec_start) begin
			limit_addr <= region_limit(rec_track);
		end
	end

	always_ff @(posedge pb_clk or posedge pb_reset) begin
		if (pb_reset) begin
			recording <= 1'b0;
			rec_done <= 1'b0;
			rec_address <= '0;
			end_address <= '0;
		end else begin
			rec_done <= 1'b0;
			if (rec_start) begin
				recording <= 1'b1;
				rec_address <= region_base(rec_track);
			end else if (recording) begin
				// Current address is written this cycle, so it is the last one
				if (rec_stop || (rec_address == limit_addr)) begin
					recording <= 1'b0;
					rec_done <= 1'b1;
					end_address <= rec_address;
				end else begin
					rec_address <= rec_address + 1'b1;
				end
			end
		end
	end

endmodule

// File: src/track_directory.sv
`timescale 1ns/1ps

module track_directory (
	input logic pb_clk,
	input logic pb_reset,
	input logic alloc,
	input logic del_one,
	input logic del_all,
	input logic rec_done,
	input recorder_pkg::track_idx_t del_track,
	input recorder_pkg::addr_t end_address,
	output logic alloc_ok,
	output logic full,
	output recorder_pkg::track_idx_t alloc_track,
	output recorder_pkg::track_mask_t track_valid
);
	import recorder_pkg::*;

	// End address of each recorded track
	addr_t end_addr [NUM_TRACKS];

	track_idx_t free_idx;
	logic free_any;

	////////////////////////////////////////
	// Lowest free track
	////////////////////////////////////////

	// Walk downward so the lowest free index wins
	always_comb begin
		free_idx = '0;
		free_any = 1'b0;
		for (int i = NUM_TRACKS - 1; i >= 0; i--) begin
			if (!track_valid[i]) begin
				free_idx = track_idx_t'(i);
				free_any = 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Valid bits and allocation
	////////////////////////////////////////

	always_ff @(posedge pb_clk or posedge pb_reset) begin
		if (pb_reset) begin
			track_valid <= '0;
			alloc_ok <= 1'b0;
			alloc_track <= '0;
		end else begin
			alloc_ok <= 1'b0;
			if (del_all) begin
				track_valid <= '0;
			end else if (del_one) begin
				track_valid[del_track] <= 1'b0;
			end else if (alloc && free_any) begin
				// Claim the region now, the end address follows later
				track_valid[free_idx] <= 1'b1;
				alloc_track <= free_idx;
				alloc_ok <= 1'b1;
			end
		end
	end

	// Region being recorded is the one last allocated
	always_ff @(posedge pb_clk or posedge pb_reset) begin
		if (pb_reset) begin
			for (int i = 0; i < NUM_TRACKS; i++) begin
				end_addr[i] <= '0;
			end
		end else if (rec_done) begin
			end_addr[alloc_track] <= end_address;
		end
	end

	// No free region left
	assign full = &track_valid;

endmodule

// File: src/keypad_decoder.sv
`timescale 1ns/1ps

module keypad_decoder (
	input logic pb_clk,
	input logic pb_reset,
	input logic [recorder_pkg::KEYPAD_LINES-1:0] row_clean,
	input logic [recorder_pkg::KEYPAD_LINES-1:0] col_clean,
	output recorder_pkg::key_t key,
	output logic key_press
);
	import recorder_pkg::*;

	key_t key_dec;

	// Exactly one row and one column, rows in the upper nibble
	always_comb begin
		case ({row_clean, col_clean})
			8'b0001_0001: key_dec = KEY_1;
			8'b0001_0010: key_dec = KEY_2;
			8'b0001_0100: key_dec = KEY_3;
			8'b0001_1000: key_dec = KEY_A;
			8'b0010_0001: key_dec = KEY_4;
			8'b0010_0010: key_dec = KEY_5;
			8'b0010_0100: key_dec = KEY_6;
			8'b0010_1000: key_dec = KEY_B;
			8'b1000_0001: key_dec = KEY_0;
			// Unused keys and multi-key chords
			default: key_dec = KEY_NONE;
		endcase
	end

	// Registered code doubles as the previous value for edge detection
	always_ff @(posedge pb_clk or posedge pb_reset) begin
		if (pb_reset) begin
			key <= KEY_NONE;
			key_press <= 1'b0;
		end else begin
			key <= key_dec;
			// Only a press out of the idle code counts
			key_press <= (key == KEY_NONE) && (key_dec != KEY_NONE);
		end
	end

endmodule

// File: src/keypad_debounce.sv
`timescale 1ns/1ps

module keypad_debounce (
	input logic pb_clk,
	input logic pb_reset,
	input logic [recorder_pkg::KEYPAD_LINES-1:0] kypd_row,
	input logic [recorder_pkg::KEYPAD_LINES-1:0] kypd_col,
	output logic [recorder_pkg::KEYPAD_LINES-1:0] row_clean,
	output logic [recorder_pkg::KEYPAD_LINES-1:0] col_clean
);
	import recorder_pkg::*;

	// All eight lines, rows in the low half
	logic [2*KEYPAD_LINES-1:0] raw_lines;
	logic [2*KEYPAD_LINES-1:0] clean_lines;

	logic [DEBOUNCE_DIV_W-1:0] div_cnt;
	logic sample_tick;

	assign raw_lines = {kypd_col, kypd_row};

	////////////////////////////////////////
	// Shared sampling tick
	////////////////////////////////////////

	always_ff @(posedge pb_clk or posedge pb_reset) begin
		if (pb_reset) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= sample_tick ? '0 : div_cnt + 1'b1;
		end
	end

	assign sample_tick = (div_cnt == DEBOUNCE_DIV_W'(DEBOUNCE_DIV - 1));

	////////////////////////////////////////
	// One debouncer per line
	////////////////////////////////////////

	for (genvar i = 0; i < 2 * KEYPAD_LINES; i++) begin : g_line
		logic sync_meta;
		logic sync_q;
		logic clean_q;
		logic [DEBOUNCE_CNT_W-1:0] stable_cnt;

		always_ff @(posedge pb_clk or posedge pb_reset) begin
			if (pb_reset) begin
				sync_meta <= 1'b0;
				sync_q <= 1'b0;
				clean_q <= 1'b0;
				stable_cnt <= '0;
			end else begin
				// Two-stage synchronizer on the raw pin
				sync_meta <= raw_lines[i];
				sync_q <= sync_meta;
				if (sample_tick) begin
					// Any sample equal to the clean level restarts the count
					if (sync_q == clean_q) begin
						stable_cnt <= '0;
					end else if (stable_cnt == DEBOUNCE_CNT_W'(DEBOUNCE_COUNT - 1)) begin
						clean_q <= sync_q;
						stable_cnt <= '0;
					end else begin
						stable_cnt <= stable_cnt + 1'b1;
					end
				end
			end
		end

		assign clean_lines[i] = clean_q;
	end

	assign row_clean = clean_lines[KEYPAD_LINES-1:0];
	assign col_clean = clean_lines[2*KEYPAD_LINES-1:KEYPAD_LINES];

endmodule

// File: src/recorder_pkg.sv
package recorder_pkg;

	////////////////////////////////////////
	// Sizes and geometry
	////////////////////////////////////////

	// Keypad matrix, rows and columns
	localparam int KEYPAD_LINES = 4;

	// Recording address space
	localparam int ADDR_W = 16;
	localparam int NUM_TRACKS = 5;
	// Kept small so a region fills quickly
	localparam int TRACK_SPAN = 64;

	// Volume setting
	localparam int VOLUME_W = 3;

	// Debounce sampling
	localparam int DEBOUNCE_DIV = 4;
	localparam int DEBOUNCE_COUNT = 3;
	localparam int DEBOUNCE_DIV_W = $clog2(DEBOUNCE_DIV);
	localparam int DEBOUNCE_CNT_W = $clog2(DEBOUNCE_COUNT);

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	typedef logic [2:0] track_idx_t;
	typedef logic [NUM_TRACKS-1:0] track_mask_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [VOLUME_W-1:0] volume_t;

	// Loudest setting
	localparam volume_t VOLUME_MAX = '1;

	// Digits keep their own value as code
	typedef enum logic [3:0] {
		KEY_0 = 4'h0,
		KEY_1 = 4'h1,
		KEY_2 = 4'h2,
		KEY_3 = 4'h3,
		KEY_4 = 4'h4,
		KEY_5 = 4'h5,
		KEY_6 = 4'h6,
		KEY_A = 4'hA,
		KEY_B = 4'hB,
		KEY_NONE = 4'hF
	} key_t;

	typedef enum logic [3:0] {
		ST_INIT,
		ST_MENU,
		ST_RECORD_INIT,
		ST_RECORD,
		ST_END_RECORD,
		ST_DELETE_MENU,
		ST_DELETE,
		ST_DELETE_ALL,
		ST_MEM_FULL,
		ST_VOLUME,
		ST_VOLUME_UP,
		ST_VOLUME_DOWN
	} menu_state_t;

	// First address of a track region
	function automatic addr_t region_base(input track_idx_t idx);
		return addr_t'(idx) * addr_t'(TRACK_SPAN);
	endfunction

	// Last address of a track region
	function automatic addr_t region_limit(input track_idx_t idx);
		return region_base(idx) + addr_t'(TRACK_SPAN - 1);
	endfunction

endpackage
